//--- rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

	localparam int DATA_W = 32;
	localparam int SHAMT_W = 5;

	// Operand and result word
	typedef logic [DATA_W-1:0] word_t;

	typedef logic [SHAMT_W-1:0] shamt_t;

	// Encodings 8 and above are illegal and answer with an exception
	typedef enum logic [4:0] {
		OP_ADD = 5'd0,
		OP_SUB = 5'd1,
		OP_AND = 5'd2,
		OP_OR  = 5'd3,
		OP_SLL = 5'd4,
		OP_SRA = 5'd5,
		OP_MUL = 5'd6,
		OP_DIV = 5'd7
	} alu_op_t;

	typedef struct packed {
		alu_op_t op;
		word_t   operand_a;
		word_t   operand_b;
		shamt_t  shamt;
	} alu_req_t;

	// Flags always compare operand_a with operand_b as signed values
	typedef struct packed {
		word_t result;
		logic  not_equal;
		logic  less_than;
		logic  exception;
	} alu_rsp_t;

endpackage

`default_nettype wire

//--- rtl/carry_select_adder.sv
`default_nettype none

module carry_select_adder #(
	parameter int GROUP_W = 4
) (
	input  wire alu_pkg::word_t a,
	input  wire alu_pkg::word_t b,
	input  wire                 carry_in,
	output alu_pkg::word_t      sum,
	output logic                carry_out
);
	import alu_pkg::*;

	localparam int GROUPS = DATA_W / GROUP_W;

	logic [GROUPS:0] carry;

	if (DATA_W % GROUP_W != 0) begin : g_bad_group
		$error("carry_select_adder: GROUP_W must divide DATA_W");
	end

	assign carry[0] = carry_in;

	for (genvar g = 0; g < GROUPS; g++) begin : g_group
		localparam int LO = g * GROUP_W;

		if (g == 0) begin : g_first
			// Lowest group ripples with the real carry
			assign {carry[1], sum[GROUP_W-1:0]} = {1'b0, a[GROUP_W-1:0]}
				+ {1'b0, b[GROUP_W-1:0]} + {{GROUP_W{1'b0}}, carry[0]};
		end else begin : g_upper
			logic [GROUP_W:0] with_c0;
			logic [GROUP_W:0] with_c1;

			// Both carry-in variants, picked once the lower carry settles
			assign with_c0 = {1'b0, a[LO +: GROUP_W]} + {1'b0, b[LO +: GROUP_W]};
			assign with_c1 = {1'b0, a[LO +: GROUP_W]} + {1'b0, b[LO +: GROUP_W]}
				+ {{GROUP_W{1'b0}}, 1'b1};
			assign {carry[g+1], sum[LO +: GROUP_W]} = carry[g] ? with_c1 : with_c0;
		end
	end

	assign carry_out = carry[GROUPS];

endmodule

`default_nettype wire

//--- rtl/barrel_shifter.sv
`default_nettype none

module barrel_shifter (
	input  wire alu_pkg::word_t  value,
	input  wire alu_pkg::shamt_t shamt,
	input  wire                  arith_right,
	output alu_pkg::word_t       shifted
);
	import alu_pkg::*;

	word_t stage [0:SHAMT_W];
	logic  fill;

	// Sign fill only for the arithmetic right shift
	assign fill = arith_right & value[DATA_W-1];
	assign stage[0] = value;

	// One mux stage per shift amount bit, distance doubles each stage
	for (genvar s = 0; s < SHAMT_W; s++) begin : g_stage
		localparam int STEP = 1 << s;

		assign stage[s+1] = !shamt[s] ? stage[s] :
			arith_right ? {{STEP{fill}}, stage[s][DATA_W-1:STEP]} :
			{stage[s][DATA_W-STEP-1:0], {STEP{1'b0}}};
	end

	assign shifted = stage[SHAMT_W];

endmodule

`default_nettype wire

//--- rtl/seq_multiplier.sv
`default_nettype none

module seq_multiplier (
	input  wire                 clock,
	input  wire                 arst_n,
	input  wire                 start,
	input  wire alu_pkg::word_t a,
	input  wire alu_pkg::word_t b,
	output logic                busy,
	output logic                done,
	output alu_pkg::word_t      product,
	output logic                overflow
);
	import alu_pkg::*;

	localparam int CNT_W = $clog2(DATA_W);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH
	} state_t;

	state_t              state;
	logic [CNT_W-1:0]    count;
	logic                negative;
	word_t               mcand;
	logic [2*DATA_W-1:0] acc;
	logic [DATA_W:0]     partial;
	logic [2*DATA_W-1:0] signed_acc;

	// Upper half gains the multiplicand when the current multiplier bit is set
	assign partial = {1'b0, acc[2*DATA_W-1:DATA_W]} + (acc[0] ? {1'b0, mcand} : '0);
	assign signed_acc = negative ? -acc : acc;
	assign busy = (state != IDLE);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state <= RUN;
						count <= '0;
					end
				end
				RUN: begin
					count <= count + 1'b1;
					if (count == CNT_W'(DATA_W - 1))
						state <= FINISH;
				end
				FINISH: begin
					state <= IDLE;
					done <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			IDLE: begin
				if (start) begin
					negative <= a[DATA_W-1] ^ b[DATA_W-1];
					mcand <= a[DATA_W-1] ? -a : a;
					acc <= {{DATA_W{1'b0}}, (b[DATA_W-1] ? -b : b)};
				end
			end
			RUN: acc <= {partial, acc[DATA_W-1:1]};
			FINISH: begin
				product <= signed_acc[DATA_W-1:0];
				// Product fits only if the high word is pure sign extension
				overflow <= signed_acc[2*DATA_W-1:DATA_W] != {DATA_W{signed_acc[DATA_W-1]}};
			end
			default: ;
		endcase
	end

	done_single_pulse: assert property (@(posedge clock) disable iff (!arst_n)
		done |=> !done);

endmodule

`default_nettype wire

//--- rtl/seq_divider.sv
`default_nettype none

module seq_divider (
	input  wire                 clock,
	input  wire                 arst_n,
	input  wire                 start,
	input  wire alu_pkg::word_t dividend,
	input  wire alu_pkg::word_t divisor,
	output logic                busy,
	output logic                done,
	output alu_pkg::word_t      quotient,
	output logic                fault
);
	import alu_pkg::*;

	localparam int CNT_W = $clog2(DATA_W);
	localparam word_t MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};

	typedef enum logic [1:0] {
		IDLE,
		CHECK,
		RUN,
		FINISH
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] count;
	logic             negative;
	word_t            quo;
	word_t            dvs;
	word_t            rem;
	logic [DATA_W:0]  shifted;
	logic [DATA_W:0]  trial;

	// Partial remainder takes the next dividend bit, then a trial subtract
	assign shifted = {rem, quo[DATA_W-1]};
	assign trial = shifted - {1'b0, dvs};
	assign busy = (state != IDLE);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (start)
						state <= CHECK;
				end
				CHECK: begin
					state <= RUN;
					count <= '0;
				end
				RUN: begin
					count <= count + 1'b1;
					if (count == CNT_W'(DATA_W - 1))
						state <= FINISH;
				end
				FINISH: begin
					state <= IDLE;
					done <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			IDLE: begin
				if (start) begin
					quo <= dividend;
					dvs <= divisor;
				end
			end
			CHECK: begin
				// Zero divisor or a quotient that cannot be represented
				fault <= (dvs == '0) || (quo == MOST_NEG && dvs == '1);
				negative <= quo[DATA_W-1] ^ dvs[DATA_W-1];
				quo <= quo[DATA_W-1] ? -quo : quo;
				dvs <= dvs[DATA_W-1] ? -dvs : dvs;
				rem <= '0;
			end
			RUN: begin
				// Restore on a negative trial, keep the difference otherwise
				rem <= trial[DATA_W] ? shifted[DATA_W-1:0] : trial[DATA_W-1:0];
				quo <= {quo[DATA_W-2:0], !trial[DATA_W]};
			end
			FINISH: quotient <= fault ? '0 : (negative ? -quo : quo);
			default: ;
		endcase
	end

	no_start_when_busy: assert property (@(posedge clock) disable iff (!arst_n)
		!(start && busy));

endmodule

`default_nettype wire

//--- rtl/alu_core.sv
`default_nettype none

module alu_core #(
	parameter int ADDER_GROUP = 4
) (
	input  wire                    clock,
	input  wire                    arst_n,
	input  wire alu_pkg::alu_req_t req,
	input  wire                    req_valid,
	output logic                   req_ready,
	output alu_pkg::alu_rsp_t      rsp,
	output logic                   rsp_valid,
	input  wire                    rsp_ready
);
	import alu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_UNIT,
		HOLD
	} state_t;

	state_t   state;
	alu_req_t req_q;
	logic     accept;
	logic     unit_done;
	word_t    sum;
	word_t    diff;
	word_t    shifted;
	word_t    result;
	logic     exception;
	logic     not_equal;
	logic     less_than;
	logic     mul_start;
	logic     mul_busy;
	logic     mul_done;
	logic     mul_overflow;
	word_t    mul_product;
	logic     div_start;
	logic     div_busy;
	logic     div_done;
	logic     div_fault;
	word_t    div_quotient;

	assign req_ready = (state == IDLE);
	assign rsp_valid = (state == HOLD);
	assign accept = req_valid && req_ready;

	// Sequential units start on the accepting edge, straight from the request
	assign mul_start = accept && (req.op == OP_MUL);
	assign div_start = accept && (req.op == OP_DIV);

	carry_select_adder #(.GROUP_W(ADDER_GROUP)) adder (
		.a(req_q.operand_a), .b(req_q.operand_b), .carry_in(1'b0),
		.sum(sum), .carry_out()
	);

	// A minus B as A plus inverted B plus one
	carry_select_adder #(.GROUP_W(ADDER_GROUP)) subtractor (
		.a(req_q.operand_a), .b(~req_q.operand_b), .carry_in(1'b1),
		.sum(diff), .carry_out()
	);

	barrel_shifter shifter (
		.value(req_q.operand_a), .shamt(req_q.shamt),
		.arith_right(req_q.op == OP_SRA), .shifted(shifted)
	);

	seq_multiplier multiplier (
		.clock(clock), .arst_n(arst_n), .start(mul_start),
		.a(req.operand_a), .b(req.operand_b),
		.busy(mul_busy), .done(mul_done), .product(mul_product), .overflow(mul_overflow)
	);

	seq_divider divider (
		.clock(clock), .arst_n(arst_n), .start(div_start),
		.dividend(req.operand_a), .divisor(req.operand_b),
		.busy(div_busy), .done(div_done), .quotient(div_quotient), .fault(div_fault)
	);

	assign not_equal = |diff;

	// Mixed signs decide directly, equal signs cannot overflow the difference
	always_comb begin
		case ({req_q.operand_a[DATA_W-1], req_q.operand_b[DATA_W-1]})
			2'b01: less_than = 1'b0;
			2'b10: less_than = 1'b1;
			default: less_than = diff[DATA_W-1];
		endcase
	end

	always_comb begin
		result = '0;
		exception = 1'b0;
		unit_done = 1'b1;
		case (req_q.op)
			OP_ADD: result = sum;
			OP_SUB: result = diff;
			OP_AND: result = req_q.operand_a & req_q.operand_b;
			OP_OR:  result = req_q.operand_a | req_q.operand_b;
			OP_SLL, OP_SRA: result = shifted;
			OP_MUL: begin
				result = mul_product;
				exception = mul_overflow;
				unit_done = mul_done;
			end
			OP_DIV: begin
				result = div_quotient;
				exception = div_fault;
				unit_done = div_done;
			end
			default: exception = 1'b1;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (accept) state <= WAIT_UNIT;
				WAIT_UNIT: if (unit_done) state <= HOLD;
				HOLD: if (rsp_ready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			req_q <= req;
		if (state == WAIT_UNIT && unit_done)
			rsp <= '{result: result, not_equal: not_equal,
				less_than: less_than, exception: exception};
	end

	rsp_held_stable: assert property (@(posedge clock) disable iff (!arst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

	// Units only run while a request is being worked on
	units_idle_outside_wait: assert property (@(posedge clock) disable iff (!arst_n)
		state != WAIT_UNIT |-> !mul_busy && !div_busy);

endmodule

`default_nettype wire

//--- rtl/alu_top.sv
`default_nettype none

module alu_top #(
	parameter int ADDER_GROUP = 4
) (
	input  wire                    clock,
	input  wire                    arst_n,
	input  wire alu_pkg::alu_req_t req,
	input  wire                    req_valid,
	output logic                   req_ready,
	output alu_pkg::alu_rsp_t      rsp,
	output logic                   rsp_valid,
	input  wire                    rsp_ready
);

	alu_core #(
		.ADDER_GROUP(ADDER_GROUP)
	) core (
		.clock(clock),
		.arst_n(arst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready)
	);

endmodule

`default_nettype wire

//--- dv/alu_tb_ref.svh
`ifndef ALU_TB_REF_SVH
`define ALU_TB_REF_SVH

// Expected response for one request
function automatic alu_rsp_t alu_model(input alu_req_t r);
	alu_rsp_t                 rsp;
	logic signed [DATA_W-1:0] a;
	logic signed [DATA_W-1:0] b;
	longint                   product;
	longint                   limit;

	a = r.operand_a;
	b = r.operand_b;
	rsp.result = '0;
	rsp.exception = 1'b0;
	rsp.not_equal = (a != b);
	rsp.less_than = (a < b);
	case (r.op)
		OP_ADD: rsp.result = a + b;
		OP_SUB: rsp.result = a - b;
		OP_AND: rsp.result = a & b;
		OP_OR:  rsp.result = a | b;
		OP_SLL: rsp.result = a << r.shamt;
		OP_SRA: rsp.result = a >>> r.shamt;
		OP_MUL: begin
			product = longint'(a) * longint'(b);
			limit = longint'(1) << (DATA_W - 1);
			rsp.result = word_t'(product);
			rsp.exception = (product >= limit) || (product < -limit);
		end
		OP_DIV: begin
			// Quotient not representable, or no quotient at all
			if (b == 0 || (r.operand_a == MOST_NEG && b == -1))
				rsp.exception = 1'b1;
			else
				rsp.result = a / b;
		end
		default: rsp.exception = 1'b1;
	endcase
	return rsp;
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	logic feedback;

	feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
	return {state[14:0], feedback};
endfunction

`endif

//--- dv/alu_tb.sv
`default_nettype none

module alu_tb;
	import alu_pkg::*;

	localparam int REQ_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 400;
	localparam word_t MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};

	logic        clock = 1'b0;
	logic        arst_n;
	alu_req_t    req;
	logic        req_valid;
	logic        req_ready;
	alu_rsp_t    rsp;
	logic        rsp_valid;
	logic        rsp_ready = 1'b1;
	logic        backpressure = 1'b0;
	logic [3:0]  stall_left = '0;
	logic [15:0] stim_lfsr = 16'd41638;
	logic [15:0] stall_lfsr = 16'd41638;
	logic        held = 1'b0;
	alu_rsp_t    held_rsp;
	alu_rsp_t    expected_q[$];
	int          sent = 0;
	int          received = 0;

	alu_top #(.ADDER_GROUP(4)) dut0 (
		.clock(clock),
		.arst_n(arst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready)
	);

	always #20 clock = ~clock;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			report_failure($sformatf("** Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_failure($sformatf("** Error at time %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic compare_response(input alu_rsp_t got, input alu_rsp_t exp, input string tag);
		check_word(got.result, exp.result, {tag, " result"});
		check_flag(got.not_equal, exp.not_equal, {tag, " not_equal"});
		check_flag(got.less_than, exp.less_than, {tag, " less_than"});
		check_flag(got.exception, exp.exception, {tag, " exception"});
	endtask

	// One random bit per LFSR step, newest bit lowest
	function automatic word_t random_bits(inout logic [15:0] state, input int n);
		word_t value;

		value = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			value = {value[DATA_W-2:0], state[0]};
		end
		return value;
	endfunction

	function automatic alu_req_t random_req(input alu_op_t op);
		alu_req_t r;

		r.op = op;
		r.operand_a = random_bits(stim_lfsr, DATA_W);
		r.operand_b = random_bits(stim_lfsr, DATA_W);
		r.shamt = shamt_t'(random_bits(stim_lfsr, SHAMT_W));
		return r;
	endfunction

	function automatic alu_req_t make_req(input alu_op_t op, input word_t a, input word_t b);
		alu_req_t r;

		r.op = op;
		r.operand_a = a;
		r.operand_b = b;
		r.shamt = '0;
		return r;
	endfunction

	// Sign-extended 12-bit value, keeps products inside one word
	function automatic word_t small_word(input word_t w);
		return {{(DATA_W-12){w[11]}}, w[11:0]};
	endfunction

	task automatic send_request(input alu_req_t r);
		int waited;

		waited = 0;
		@(posedge clock);
		req <= r;
		req_valid <= 1'b1;
		@(posedge clock);
		while (!req_ready) begin
			waited++;
			if (waited > REQ_TIMEOUT)
				report_failure("Timed out waiting for the ALU to accept a request");
			@(posedge clock);
		end
		req_valid <= 1'b0;
		expected_q.push_back(alu_model(r));
		sent++;
		if (r.op != OP_MUL && r.op != OP_DIV) begin
			@(negedge clock);
			check_flag(rsp_valid, 1'b0, "rsp_valid in the cycle after acceptance");
			@(negedge clock);
			check_flag(rsp_valid, 1'b1, "rsp_valid one cycle after acceptance");
		end
	endtask

	// Random stalls of up to eight cycles on the response side
	always @(posedge clock) begin
		if (!backpressure) begin
			rsp_ready <= 1'b1;
		end else if (stall_left != 0) begin
			rsp_ready <= 1'b0;
			stall_left <= stall_left - 1'b1;
		end else if (random_bits(stall_lfsr, 1) != 0) begin
			rsp_ready <= 1'b0;
			stall_left <= 4'(random_bits(stall_lfsr, 3));
		end else begin
			rsp_ready <= 1'b1;
		end
	end

	always @(posedge clock) begin
		if (arst_n) begin
			if (held) begin
				check_flag(rsp_valid, 1'b1, "rsp_valid while held");
				compare_response(rsp, held_rsp, "held response");
				check_flag(req_ready, 1'b0, "req_ready while a response is held");
			end
			if (rsp_valid && rsp_ready) begin
				if (expected_q.size() == 0)
					report_failure("A response arrived with no request outstanding");
				else
					compare_response(rsp, expected_q.pop_front(),
						$sformatf("response %0d", received));
				received++;
			end
			held = rsp_valid && !rsp_ready;
			held_rsp = rsp;
		end
	end

	initial begin
		alu_req_t r;
		int       waited;

		arst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		repeat (4) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
		check_flag(req_ready, 1'b1, "req_ready after reset");

		repeat (40) send_request(random_req(alu_op_t'(5'(random_bits(stim_lfsr, 3) % 6))));

		// All four sign combinations, unequal then equal
		for (int s = 0; s < 4; s++) begin
			r = random_req(OP_SUB);
			r.operand_a[DATA_W-1] = s[1];
			r.operand_b[DATA_W-1] = s[0];
			send_request(r);
			r.operand_b = r.operand_a;
			send_request(r);
		end
		send_request(make_req(OP_SUB, MOST_NEG, 32'd1));
		send_request(make_req(OP_ADD, 32'd5, MOST_NEG));
		send_request(make_req(OP_SUB, 32'h7fff_ffff, MOST_NEG));
		send_request(make_req(OP_AND, MOST_NEG, MOST_NEG));

		repeat (10) begin
			r = random_req(OP_MUL);
			r.operand_a = small_word(r.operand_a);
			r.operand_b = small_word(r.operand_b);
			send_request(r);
		end
		repeat (8) send_request(random_req(OP_MUL));
		send_request(make_req(OP_MUL, 32'h7fff_ffff, 32'd2));
		send_request(make_req(OP_MUL, MOST_NEG, '1));
		send_request(make_req(OP_MUL, 32'h0001_0000, 32'h0001_0000));

		repeat (12) begin
			r = random_req(OP_DIV);
			r.operand_b = small_word(r.operand_b);
			if (r.operand_b == '0)
				r.operand_b = 32'd3;
			send_request(r);
		end
		send_request(make_req(OP_DIV, 32'd7, 32'hffff_fffe));
		send_request(make_req(OP_DIV, 32'hffff_fff9, 32'd2));
		send_request(make_req(OP_DIV, random_bits(stim_lfsr, DATA_W), '0));
		send_request(make_req(OP_DIV, MOST_NEG, '1));
		send_request(make_req(OP_DIV, MOST_NEG, 32'd2));
		for (int k = 8; k < 32; k += 7)
			send_request(random_req(alu_op_t'(5'(k))));

		backpressure <= 1'b1;
		repeat (40) send_request(random_req(alu_op_t'(5'(random_bits(stim_lfsr, 3)))));

		waited = 0;
		while (received != sent) begin
			waited++;
			if (waited > DRAIN_TIMEOUT)
				report_failure("Timed out waiting for the outstanding responses");
			@(negedge clock);
		end
		// A duplicated response would keep rsp_valid up after the last transfer
		if (rsp_valid !== 1'b0 || req_ready !== 1'b1)
			report_failure($sformatf("** Error at time %0t: %s", $time,
				"ALU not idle after the last response was taken"));
		else
			$display("Test completed successfully");
		$finish;
	end

`include "alu_tb_ref.svh"

endmodule

`default_nettype wire

//--- build.f
+incdir+dv
rtl/alu_pkg.sv
rtl/carry_select_adder.sv
rtl/barrel_shifter.sv
rtl/seq_multiplier.sv
rtl/seq_divider.sv
rtl/alu_core.sv
rtl/alu_top.sv
dv/alu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module alu_tb

status=0
./obj_dir/Valu_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation passed"
